// File: Makefile
# Verilator build and run of the token engine testbench

VERILATOR ?= verilator
TOP       ?= tb_token_engine
LINT_TOP  ?= token_engine
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -qF "*** TEST PASSED ***" $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: filelist.f
+incdir+hw
hw/token_engine_pkg.sv
hw/pass_sequencer.sv
hw/weight_loader.sv
hw/lane_fifo_ctrl.sv
hw/token_arbiter.sv
hw/token_engine.sv
tests/glb_wb_model.sv
tests/tb_token_engine.sv

// File: hw/lane_fifo_ctrl.sv
// opsum FIFOs must be first-word fall-through; at most one GLB request per lane and direction
`timescale 1ns/1ps
`include "token_engine_params.svh"

module lane_fifo_ctrl (
    input  logic                         clk,
    input  logic                         rst_n_i,
    input  logic                         init_state_i,
    input  logic                         stream_state_i,
    input  token_engine_pkg::glb_addr_t  ifmap_base_i,
    input  token_engine_pkg::glb_addr_t  opsum_base_i,
    input  token_engine_pkg::tile_len_t  tile_len_i,
    input  token_engine_pkg::lane_mask_t ifmap_fifo_full_i,
    input  token_engine_pkg::lane_mask_t opsum_fifo_empty_i,
    input  token_engine_pkg::glb_data_t  opsum_fifo_pop_data_i [`TE_NUM_LANES],
    input  token_engine_pkg::lane_mask_t rd_grant_i,
    input  token_engine_pkg::lane_mask_t wr_grant_i,
    input  token_engine_pkg::glb_data_t  glb_rd_data_i,
    output logic                         ifmap_fifo_reset_o,
    output logic                         opsum_fifo_reset_o,
    output token_engine_pkg::lane_mask_t ifmap_fifo_push_o,
    output token_engine_pkg::glb_data_t  ifmap_fifo_push_data_o,
    output token_engine_pkg::lane_mask_t opsum_fifo_pop_o,
    output token_engine_pkg::lane_mask_t rd_req_o,
    output token_engine_pkg::glb_addr_t  rd_addr_o [`TE_NUM_LANES],
    output token_engine_pkg::lane_mask_t wr_req_o,
    output token_engine_pkg::glb_addr_t  wr_addr_o [`TE_NUM_LANES],
    output token_engine_pkg::glb_data_t  wr_data_o [`TE_NUM_LANES],
    output logic                         stream_done_o
);

token_engine_pkg::lane_mask_t lane_done;

for (genvar l = 0; l < `TE_NUM_LANES; l++) begin : g_lane
    token_engine_pkg::glb_addr_t lane_off;  // lane l owns words l*len .. l*len+len-1
    token_engine_pkg::glb_addr_t rd_base_q;
    token_engine_pkg::glb_addr_t wr_base_q;
    token_engine_pkg::tile_len_t rd_cnt_q;  // ifmap words pushed
    token_engine_pkg::tile_len_t wr_cnt_q;  // opsum words written back
    token_engine_pkg::glb_data_t wr_data_q;
    logic                        rd_req_q;
    logic                        wr_req_q;

    assign lane_off = (token_engine_pkg::glb_addr_t'(l)
                       * token_engine_pkg::glb_addr_t'(tile_len_i)) << 2;

    assign rd_addr_o[l] = rd_base_q + (token_engine_pkg::glb_addr_t'(rd_cnt_q) << 2);
    assign wr_addr_o[l] = wr_base_q + (token_engine_pkg::glb_addr_t'(wr_cnt_q) << 2);
    assign wr_data_o[l] = wr_data_q;
    assign rd_req_o[l]  = rd_req_q;
    assign wr_req_o[l]  = wr_req_q;

    assign ifmap_fifo_push_o[l] = rd_req_q & rd_grant_i[l];  // word lands with the grant
    assign opsum_fifo_pop_o[l]  = stream_state_i & ~wr_req_q & ~opsum_fifo_empty_i[l]
                                  & (wr_cnt_q < tile_len_i);
    assign lane_done[l]         = (rd_cnt_q == tile_len_i) && (wr_cnt_q == tile_len_i);

    always_ff @(posedge clk) begin
        if (!rst_n_i || init_state_i) begin
            rd_req_q <= 1'b0;
            wr_req_q <= 1'b0;
            rd_cnt_q <= '0;
            wr_cnt_q <= '0;
        end else begin
            if (rd_req_q && rd_grant_i[l]) begin
                rd_req_q <= 1'b0;
                rd_cnt_q <= rd_cnt_q + 1'b1;
            end else if (stream_state_i && !rd_req_q && !ifmap_fifo_full_i[l]
                         && rd_cnt_q < tile_len_i) begin
                rd_req_q <= 1'b1;  // room in the lane, fetch the next word
            end
            if (wr_req_q && wr_grant_i[l]) begin
                wr_req_q <= 1'b0;
                wr_cnt_q <= wr_cnt_q + 1'b1;
            end else if (opsum_fifo_pop_o[l]) begin
                wr_req_q <= 1'b1;  // held until the write is acked
            end
        end
    end

    always_ff @(posedge clk) begin
        if (init_state_i) begin
            rd_base_q <= ifmap_base_i + lane_off;
            wr_base_q <= opsum_base_i + lane_off;
        end
        if (opsum_fifo_pop_o[l]) begin
            wr_data_q <= opsum_fifo_pop_data_i[l];
        end
    end

    // the request is only raised with room, and nothing else pushes this lane
    a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n_i)
        ifmap_fifo_push_o[l] |-> !ifmap_fifo_full_i[l]);
end

assign ifmap_fifo_reset_o     = init_state_i;
assign opsum_fifo_reset_o     = init_state_i;
assign ifmap_fifo_push_data_o = glb_rd_data_i;  // one grant per cycle, so one shared word
assign stream_done_o          = stream_state_i & (&lane_done);

endmodule

// File: hw/pass_sequencer.sv
// a start pulse seen outside IDLE is ignored; pass_done_o is a single-cycle pulse
`timescale 1ns/1ps
`include "token_engine_params.svh"

module pass_sequencer (
    input  logic clk,
    input  logic rst_n_i,
    input  logic pass_start_i,
    input  logic weight_load_done_i,
    input  logic stream_done_i,
    output logic pass_done_o,
    output logic weight_load_state_o,
    output logic init_state_o,
    output logic stream_state_o
);

token_engine_pkg::pass_state_e state_q;
token_engine_pkg::pass_state_e state_d;

always_comb begin
    state_d = state_q;
    case (state_q)
        token_engine_pkg::IDLE:        if (pass_start_i) state_d = token_engine_pkg::WEIGHT_LOAD;
        token_engine_pkg::WEIGHT_LOAD: if (weight_load_done_i) state_d = token_engine_pkg::INIT_FIFO;
        token_engine_pkg::INIT_FIFO:   state_d = token_engine_pkg::STREAM;  // always one cycle
        token_engine_pkg::STREAM:      if (stream_done_i) state_d = token_engine_pkg::DONE;
        token_engine_pkg::DONE:        state_d = token_engine_pkg::IDLE;
        default:                       state_d = token_engine_pkg::IDLE;
    endcase
end

always_ff @(posedge clk) begin
    if (!rst_n_i) begin
        state_q <= token_engine_pkg::IDLE;
    end else begin
        state_q <= state_d;
    end
end

assign weight_load_state_o = (state_q == token_engine_pkg::WEIGHT_LOAD);
assign init_state_o        = (state_q == token_engine_pkg::INIT_FIFO);
assign stream_state_o      = (state_q == token_engine_pkg::STREAM);
assign pass_done_o         = (state_q == token_engine_pkg::DONE);  // high only on entry cycle

// the lower controllers assume exactly one active phase while a pass runs
a_one_phase: assert property (@(posedge clk) disable iff (!rst_n_i)
    (state_q != token_engine_pkg::IDLE && state_q != token_engine_pkg::DONE)
        |-> $onehot({weight_load_state_o, init_state_o, stream_state_o}));

endmodule

// File: hw/token_arbiter.sv
// one Wishbone classic transaction at a time; grants and read data come back in the ack cycle
`timescale 1ns/1ps
`include "token_engine_params.svh"

module token_arbiter (
    input  logic                            clk,
    input  logic                            rst_n_i,
    input  logic                            weight_load_state_i,
    input  logic                            weight_rd_req_i,
    input  token_engine_pkg::glb_addr_t     weight_rd_addr_i,
    input  token_engine_pkg::lane_mask_t    rd_req_i,
    input  token_engine_pkg::glb_addr_t     rd_addr_i [`TE_NUM_LANES],
    input  token_engine_pkg::lane_mask_t    wr_req_i,
    input  token_engine_pkg::glb_addr_t     wr_addr_i [`TE_NUM_LANES],
    input  token_engine_pkg::glb_data_t     wr_data_i [`TE_NUM_LANES],
    input  token_engine_pkg::glb_data_t     wb_dat_i,
    input  logic                            wb_ack_i,
    output logic                            wb_cyc_o,
    output logic                            wb_stb_o,
    output logic                            wb_we_o,
    output token_engine_pkg::glb_addr_t     wb_adr_o,
    output token_engine_pkg::glb_data_t     wb_dat_o,
    output logic [`TE_DATA_W/8-1:0]         wb_sel_o,
    output logic                            weight_grant_o,
    output token_engine_pkg::lane_mask_t    rd_grant_o,
    output token_engine_pkg::lane_mask_t    wr_grant_o,
    output token_engine_pkg::glb_data_t     glb_rd_data_o
);

localparam int LANE_W = $clog2(`TE_NUM_LANES);
localparam int REQ_W  = LANE_W + 1;  // top bit set for opsum writes

logic [2*`TE_NUM_LANES-1:0]  req_vec;
logic [REQ_W-1:0]            ptr_q;    // last granted request
logic [REQ_W-1:0]            owner_q;
logic [REQ_W-1:0]            pick_idx;
logic [LANE_W-1:0]           pick_lane;
logic                        pick_valid;
logic                        busy_q;
logic                        stb_q;
logic                        we_q;
logic                        wt_owner_q;
logic                        lane_ack;
token_engine_pkg::glb_addr_t adr_q;
token_engine_pkg::glb_data_t dat_q;

assign req_vec   = {wr_req_i, rd_req_i};
assign pick_lane = pick_idx[LANE_W-1:0];

// first pending request after the pointer, wrapping
always_comb begin
    logic [REQ_W-1:0] cand;
    pick_valid = 1'b0;
    pick_idx   = ptr_q;
    for (int i = 1; i <= 2 * `TE_NUM_LANES; i++) begin
        cand = ptr_q + REQ_W'(i);
        if (!pick_valid && req_vec[cand]) begin
            pick_valid = 1'b1;
            pick_idx   = cand;
        end
    end
end

always_ff @(posedge clk) begin
    if (!rst_n_i) begin
        busy_q     <= 1'b0;
        stb_q      <= 1'b0;
        we_q       <= 1'b0;
        wt_owner_q <= 1'b0;
        ptr_q      <= '1;  // so lane 0 read goes first
    end else if (busy_q) begin
        if (wb_ack_i) begin
            busy_q <= 1'b0;
            stb_q  <= 1'b0;
        end
    end else if (weight_load_state_i) begin
        if (weight_rd_req_i) begin  // weight phase serves the loader only
            busy_q     <= 1'b1;
            stb_q      <= 1'b1;
            we_q       <= 1'b0;
            wt_owner_q <= 1'b1;
        end
    end else if (pick_valid) begin
        busy_q     <= 1'b1;
        stb_q      <= 1'b1;
        we_q       <= pick_idx[LANE_W];
        wt_owner_q <= 1'b0;
        ptr_q      <= pick_idx;
    end
end

// address and data follow the pick while idle, frozen while busy
always_ff @(posedge clk) begin
    if (!busy_q) begin
        owner_q <= pick_idx;
        dat_q   <= wr_data_i[pick_lane];
        if (weight_load_state_i) begin
            adr_q <= weight_rd_addr_i;
        end else begin
            adr_q <= pick_idx[LANE_W] ? wr_addr_i[pick_lane] : rd_addr_i[pick_lane];
        end
    end
end

assign wb_cyc_o = busy_q;
assign wb_stb_o = stb_q;
assign wb_we_o  = we_q;
assign wb_adr_o = adr_q;
assign wb_dat_o = dat_q;
assign wb_sel_o = '1;

assign lane_ack       = busy_q & wb_ack_i & ~wt_owner_q;
assign weight_grant_o = busy_q & wb_ack_i & wt_owner_q;
assign rd_grant_o     = (lane_ack && !owner_q[LANE_W])
                        ? (token_engine_pkg::lane_mask_t'(1) << owner_q[LANE_W-1:0]) : '0;
assign wr_grant_o     = (lane_ack && owner_q[LANE_W])
                        ? (token_engine_pkg::lane_mask_t'(1) << owner_q[LANE_W-1:0]) : '0;
assign glb_rd_data_o  = wb_dat_i;

a_stb_in_cyc: assert property (@(posedge clk) disable iff (!rst_n_i)
    wb_stb_o |-> wb_cyc_o);

// the slave may take any number of cycles to ack
a_hold_until_ack: assert property (@(posedge clk) disable iff (!rst_n_i)
    (wb_cyc_o && !wb_ack_i) |=> (wb_cyc_o && $stable(wb_adr_o) && $stable(wb_dat_o)));

endmodule

// File: hw/token_engine.sv
// config inputs must hold for a whole pass; FIFO storage and PE array sit outside
`timescale 1ns/1ps
`include "token_engine_params.svh"

module token_engine (
    input  logic                         clk,
    input  logic                         rst_n_i,
    input  logic                         pass_start_i,
    output logic                         pass_done_o,
    input  token_engine_pkg::glb_addr_t  weight_base_i,
    input  token_engine_pkg::glb_addr_t  ifmap_base_i,
    input  token_engine_pkg::glb_addr_t  opsum_base_i,
    input  token_engine_pkg::tile_len_t  tile_len_i,
    output logic                         wb_cyc_o,
    output logic                         wb_stb_o,
    output logic                         wb_we_o,
    output token_engine_pkg::glb_addr_t  wb_adr_o,
    output token_engine_pkg::glb_data_t  wb_dat_o,
    output logic [`TE_DATA_W/8-1:0]      wb_sel_o,
    input  token_engine_pkg::glb_data_t  wb_dat_i,
    input  logic                         wb_ack_i,
    output token_engine_pkg::weight_t    weight_o,
    output token_engine_pkg::lane_mask_t weight_load_en_o,
    output logic                         ifmap_fifo_reset_o,
    output token_engine_pkg::lane_mask_t ifmap_fifo_push_o,
    output token_engine_pkg::glb_data_t  ifmap_fifo_push_data_o,
    input  token_engine_pkg::lane_mask_t ifmap_fifo_full_i,
    output logic                         opsum_fifo_reset_o,
    output token_engine_pkg::lane_mask_t opsum_fifo_pop_o,
    input  token_engine_pkg::glb_data_t  opsum_fifo_pop_data_i [`TE_NUM_LANES],
    input  token_engine_pkg::lane_mask_t opsum_fifo_empty_i
);

logic                         weight_load_state;
logic                         init_state;
logic                         stream_state;
logic                         weight_load_done;
logic                         stream_done;
logic                         weight_rd_req;
logic                         weight_grant;
token_engine_pkg::glb_addr_t  weight_rd_addr;
token_engine_pkg::lane_mask_t ifmap_rd_req;
token_engine_pkg::lane_mask_t opsum_wr_req;
token_engine_pkg::lane_mask_t rd_grant;
token_engine_pkg::lane_mask_t wr_grant;
token_engine_pkg::glb_addr_t  ifmap_rd_addr [`TE_NUM_LANES];
token_engine_pkg::glb_addr_t  opsum_wr_addr [`TE_NUM_LANES];
token_engine_pkg::glb_data_t  opsum_wr_data [`TE_NUM_LANES];
token_engine_pkg::glb_data_t  glb_rd_data;

pass_sequencer u_pass_sequencer (
    .clk(clk), .rst_n_i(rst_n_i),
    .pass_start_i(pass_start_i), .weight_load_done_i(weight_load_done),
    .stream_done_i(stream_done), .pass_done_o(pass_done_o),
    .weight_load_state_o(weight_load_state), .init_state_o(init_state),
    .stream_state_o(stream_state)
);

weight_loader u_weight_loader (
    .clk(clk), .rst_n_i(rst_n_i),
    .weight_load_state_i(weight_load_state), .weight_base_i(weight_base_i),
    .grant_done_i(weight_grant), .glb_rd_data_i(glb_rd_data),
    .rd_req_o(weight_rd_req), .rd_addr_o(weight_rd_addr),
    .weight_o(weight_o), .weight_load_en_o(weight_load_en_o),
    .weight_load_done_o(weight_load_done)
);

lane_fifo_ctrl u_lane_fifo_ctrl (
    .clk(clk), .rst_n_i(rst_n_i),
    .init_state_i(init_state), .stream_state_i(stream_state),
    .ifmap_base_i(ifmap_base_i), .opsum_base_i(opsum_base_i), .tile_len_i(tile_len_i),
    .ifmap_fifo_full_i(ifmap_fifo_full_i), .opsum_fifo_empty_i(opsum_fifo_empty_i),
    .opsum_fifo_pop_data_i(opsum_fifo_pop_data_i),
    .rd_grant_i(rd_grant), .wr_grant_i(wr_grant), .glb_rd_data_i(glb_rd_data),
    .ifmap_fifo_reset_o(ifmap_fifo_reset_o), .opsum_fifo_reset_o(opsum_fifo_reset_o),
    .ifmap_fifo_push_o(ifmap_fifo_push_o), .ifmap_fifo_push_data_o(ifmap_fifo_push_data_o),
    .opsum_fifo_pop_o(opsum_fifo_pop_o),
    .rd_req_o(ifmap_rd_req), .rd_addr_o(ifmap_rd_addr),
    .wr_req_o(opsum_wr_req), .wr_addr_o(opsum_wr_addr), .wr_data_o(opsum_wr_data),
    .stream_done_o(stream_done)
);

token_arbiter u_token_arbiter (
    .clk(clk), .rst_n_i(rst_n_i),
    .weight_load_state_i(weight_load_state),
    .weight_rd_req_i(weight_rd_req), .weight_rd_addr_i(weight_rd_addr),
    .rd_req_i(ifmap_rd_req), .rd_addr_i(ifmap_rd_addr),
    .wr_req_i(opsum_wr_req), .wr_addr_i(opsum_wr_addr), .wr_data_i(opsum_wr_data),
    .wb_dat_i(wb_dat_i), .wb_ack_i(wb_ack_i),
    .wb_cyc_o(wb_cyc_o), .wb_stb_o(wb_stb_o), .wb_we_o(wb_we_o),
    .wb_adr_o(wb_adr_o), .wb_dat_o(wb_dat_o), .wb_sel_o(wb_sel_o),
    .weight_grant_o(weight_grant), .rd_grant_o(rd_grant), .wr_grant_o(wr_grant),
    .glb_rd_data_o(glb_rd_data)
);

endmodule

// File: hw/token_engine_params.svh
// lane count must be a power of two and at least 2; the GLB word must hold a power-of-two byte count
`ifndef TOKEN_ENGINE_PARAMS_SVH
`define TOKEN_ENGINE_PARAMS_SVH

// lanes of the PE array served by one engine
`define TE_NUM_LANES 4

`define TE_ADDR_W 32   // GLB byte address
`define TE_DATA_W 32   // GLB word
`define TE_LEN_W  8    // words per lane per pass

`endif

// File: hw/token_engine_pkg.sv
// shared types of the token engine; widths come from the params header
`include "token_engine_params.svh"

package token_engine_pkg;

    typedef logic [`TE_ADDR_W-1:0]    glb_addr_t;
    typedef logic [`TE_DATA_W-1:0]    glb_data_t;
    typedef logic [`TE_NUM_LANES-1:0] lane_mask_t;  // one bit per lane
    typedef logic [`TE_LEN_W-1:0]     tile_len_t;
    typedef logic [7:0]               weight_t;

    // pass phases, one at a time
    typedef enum logic [2:0] {
        IDLE,
        WEIGHT_LOAD,
        INIT_FIFO,
        STREAM,
        DONE
    } pass_state_e;

endpackage

// File: hw/weight_loader.sv
// one GLB read per lane, then its bytes low first; weight_base_i must stay stable for the phase
`timescale 1ns/1ps
`include "token_engine_params.svh"

module weight_loader (
    input  logic                         clk,
    input  logic                         rst_n_i,
    input  logic                         weight_load_state_i,
    input  token_engine_pkg::glb_addr_t  weight_base_i,
    input  logic                         grant_done_i,
    input  token_engine_pkg::glb_data_t  glb_rd_data_i,
    output logic                         rd_req_o,
    output token_engine_pkg::glb_addr_t  rd_addr_o,
    output token_engine_pkg::weight_t    weight_o,
    output token_engine_pkg::lane_mask_t weight_load_en_o,
    output logic                         weight_load_done_o
);

localparam int LANE_W = $clog2(`TE_NUM_LANES);
localparam int BYTE_W = $clog2(`TE_DATA_W / 8);

logic                        rd_req_q;
logic                        shift_q;     // bytes of word_q going out
logic                        done_q;
logic                        finished_q;  // all lanes loaded, wait for phase end
logic [LANE_W-1:0]           lane_q;
logic [BYTE_W-1:0]           byte_q;
token_engine_pkg::glb_data_t word_q;

always_ff @(posedge clk) begin
    if (!rst_n_i) begin
        rd_req_q   <= 1'b0;
        shift_q    <= 1'b0;
        done_q     <= 1'b0;
        finished_q <= 1'b0;
        lane_q     <= '0;
        byte_q     <= '0;
    end else begin
        done_q <= 1'b0;
        if (!weight_load_state_i) begin
            finished_q <= 1'b0;  // rearm for the next pass
            lane_q     <= '0;
        end else if (rd_req_q) begin
            if (grant_done_i) begin
                rd_req_q <= 1'b0;
                shift_q  <= 1'b1;
                byte_q   <= '0;
            end
        end else if (shift_q) begin
            byte_q <= byte_q + 1'b1;
            if (&byte_q) begin
                shift_q <= 1'b0;
                if (lane_q == LANE_W'(`TE_NUM_LANES - 1)) begin
                    done_q     <= 1'b1;
                    finished_q <= 1'b1;
                end else begin
                    lane_q <= lane_q + 1'b1;
                end
            end
        end else if (!finished_q) begin
            rd_req_q <= 1'b1;  // fetch the word of lane_q
        end
    end
end

always_ff @(posedge clk) begin
    if (rd_req_q && grant_done_i) begin
        word_q <= glb_rd_data_i;
    end
end

assign rd_req_o           = rd_req_q;
assign rd_addr_o          = weight_base_i + (token_engine_pkg::glb_addr_t'(lane_q) << 2);
assign weight_o           = word_q[{byte_q, 3'b000} +: 8];
assign weight_load_en_o   = shift_q ? (token_engine_pkg::lane_mask_t'(1) << lane_q) : '0;
assign weight_load_done_o = done_q;

endmodule

// File: tests/glb_wb_model.sv
// one outstanding transaction; word index is adr_i[IDX_W+1:2], upper address bits are ignored
`timescale 1ns/1ps
`include "token_engine_params.svh"

module glb_wb_model #(
    parameter int WORDS = 1024
) (
    input  logic                        clk,
    input  logic                        rst_n_i,
    input  logic                        cyc_i,
    input  logic                        stb_i,
    input  logic                        we_i,
    input  token_engine_pkg::glb_addr_t adr_i,
    input  token_engine_pkg::glb_data_t dat_i,
    input  logic [`TE_DATA_W/8-1:0]     sel_i,
    input  logic [2:0]                  ack_delay_i,  // wait cycles before ack
    output token_engine_pkg::glb_data_t dat_o,
    output logic                        ack_o
);

localparam int IDX_W = $clog2(WORDS);

token_engine_pkg::glb_data_t mem [WORDS];
token_engine_pkg::glb_data_t dat_q = '0;
logic                        ack_q = 1'b0;
logic [2:0]                  wait_q = '0;
logic [IDX_W-1:0]            idx;

assign idx = adr_i[IDX_W+1:2];

// slave answers on the falling edge, the master samples ack on the rising one
always @(negedge clk) begin
    if (!rst_n_i || ack_q || !(cyc_i && stb_i)) begin
        ack_q  <= 1'b0;  // ack lasts one cycle
        wait_q <= '0;
    end else if (wait_q >= ack_delay_i) begin
        ack_q <= 1'b1;
        dat_q <= mem[idx];
        for (int b = 0; b < `TE_DATA_W / 8; b++) begin
            if (we_i && sel_i[b]) begin
                mem[idx][8*b +: 8] <= dat_i[8*b +: 8];
            end
        end
    end else begin
        wait_q <= wait_q + 1'b1;
    end
end

assign dat_o = dat_q;
assign ack_o = ack_q;

endmodule

// File: tests/tb_token_engine.sv
// four lanes with depth-4 FIFO models and a PE stand-in; GLB image sits in the Wishbone model
`timescale 1ns/1ps
`include "token_engine_params.svh"

module tb_token_engine;

localparam int NL         = `TE_NUM_LANES;
localparam int FIFO_DEPTH = 4;
localparam int MEM_WORDS  = 1024;
localparam int TIMEOUT    = 20000;  // cycles per wait
localparam int FULL_HOLD  = 16;     // cycles a held lane must sit full

logic                         clk = 1'b0;
logic                         rst_n_i = 1'b0;
logic                         pass_start_i = 1'b0;
logic                         pass_done_o;
token_engine_pkg::glb_addr_t  weight_base_i = '0;
token_engine_pkg::glb_addr_t  ifmap_base_i = '0;
token_engine_pkg::glb_addr_t  opsum_base_i = '0;
token_engine_pkg::tile_len_t  tile_len_i = '0;
logic                         wb_cyc_o;
logic                         wb_stb_o;
logic                         wb_we_o;
token_engine_pkg::glb_addr_t  wb_adr_o;
token_engine_pkg::glb_data_t  wb_dat_o;
logic [`TE_DATA_W/8-1:0]      wb_sel_o;
token_engine_pkg::glb_data_t  wb_dat_i;
logic                         wb_ack_i;
token_engine_pkg::weight_t    weight_o;
token_engine_pkg::lane_mask_t weight_load_en_o;
logic                         ifmap_fifo_reset_o;
token_engine_pkg::lane_mask_t ifmap_fifo_push_o;
token_engine_pkg::glb_data_t  ifmap_fifo_push_data_o;
token_engine_pkg::lane_mask_t ifmap_fifo_full_i = '0;
logic                         opsum_fifo_reset_o;
token_engine_pkg::lane_mask_t opsum_fifo_pop_o;
token_engine_pkg::glb_data_t  opsum_fifo_pop_data_i [NL] = '{default: '0};
token_engine_pkg::lane_mask_t opsum_fifo_empty_i = '1;
logic [2:0]                   ack_delay = '0;

token_engine_pkg::glb_data_t  image [MEM_WORDS];  // GLB content before any pass
token_engine_pkg::glb_data_t  ifmap_q [NL][$];
token_engine_pkg::glb_data_t  opsum_q [NL][$];
int                           pe_wait [NL];
int                           push_cnt [NL];
int                           byte_cnt [NL];
int                           full_cycles [NL];
int                           done_cnt = 0;
token_engine_pkg::lane_mask_t pe_hold = '0;  // PE lanes stalled until their ifmap FIFO filled
logic [31:0]                  lfsr_q = 32'h25b;
logic                         hold_q = 1'b0;   // Wishbone transaction waiting for ack
token_engine_pkg::glb_addr_t  adr_s;
token_engine_pkg::glb_data_t  dat_s;

token_engine u_token_engine (.*);

glb_wb_model #(.WORDS(MEM_WORDS)) u_glb_wb_model (
    .clk(clk), .rst_n_i(rst_n_i), .cyc_i(wb_cyc_o), .stb_i(wb_stb_o), .we_i(wb_we_o),
    .adr_i(wb_adr_o), .dat_i(wb_dat_o), .sel_i(wb_sel_o), .ack_delay_i(ack_delay),
    .dat_o(wb_dat_i), .ack_o(wb_ack_i)
);

initial forever #50 clk = ~clk;

// Galois LFSR, one step per bit taken
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
        r      = {r[30:0], lfsr_q[0]};
        lfsr_q = {1'b0, lfsr_q[31:1]} ^ (lfsr_q[0] ? 32'h8020_0003 : 32'h0);
    end
    return r;
endfunction

function automatic int lane_word(input token_engine_pkg::glb_addr_t base, input int l,
                                 input int k);
    return int'(base >> 2) + l * int'(tile_len_i) + k;
endfunction

function automatic token_engine_pkg::weight_t expect_weight(input int l, input int b);
    return image[int'(weight_base_i >> 2) + l][8*b +: 8];
endfunction

function automatic token_engine_pkg::glb_data_t expect_ifmap(input int l, input int k);
    return image[lane_word(ifmap_base_i, l, k)];
endfunction

// word k of lane l leaves the PE as the ifmap word plus the lane number
function automatic token_engine_pkg::glb_data_t expect_opsum(input int l, input int k);
    return expect_ifmap(l, k) + token_engine_pkg::glb_data_t'(l);
endfunction

// only the opsum region of the running pass is ever written
function automatic logic in_opsum_region(input token_engine_pkg::glb_addr_t adr);
    return adr >= opsum_base_i
           && adr < opsum_base_i + token_engine_pkg::glb_addr_t'(4 * NL * int'(tile_len_i));
endfunction

task automatic fail_run(input string why);
    $display("%s", why);
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped");
endtask

task automatic check_byte(input string name, input token_engine_pkg::weight_t exp,
                          input token_engine_pkg::weight_t act);
    if (act !== exp) fail_run($sformatf("Fail %s: expected %h, actual %h", name, exp, act));
endtask

task automatic check_word(input string name, input token_engine_pkg::glb_data_t exp,
                          input token_engine_pkg::glb_data_t act);
    if (act !== exp) fail_run($sformatf("Fail %s: expected %h, actual %h", name, exp, act));
endtask

task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) fail_run($sformatf("Fail %s: expected %b, actual %b", name, exp, act));
endtask

task automatic check_count(input string name, input int exp, input int act);
    if (act != exp) fail_run($sformatf("Fail %s: expected %0d, actual %0d", name, exp, act));
endtask

// FIFO models, PE stand-in and online checks, all on values settled before the edge
always @(posedge clk) begin
    if (!rst_n_i) begin
        hold_q = 1'b0;
        for (int l = 0; l < NL; l++) begin
            ifmap_q[l].delete();
            opsum_q[l].delete();
            pe_wait[l] = 0;
        end
    end else begin
        if (hold_q) begin
            if (!wb_cyc_o) fail_run("Wishbone cycle dropped before ack");
            check_word("wb_adr_o held until ack", adr_s, wb_adr_o);
            check_word("wb_dat_o held until ack", dat_s, wb_dat_o);
        end
        if (wb_stb_o !== wb_cyc_o) fail_run("wb_stb_o differs from wb_cyc_o");
        if (wb_cyc_o && wb_sel_o !== '1) fail_run("wb_sel_o is not all ones");
        if (wb_cyc_o) begin
            check_flag($sformatf("wb_we_o at %h", wb_adr_o), in_opsum_region(wb_adr_o),
                       wb_we_o);
        end
        hold_q = wb_cyc_o && !wb_ack_i;
        adr_s  = wb_adr_o;
        dat_s  = wb_dat_o;
        if (pass_done_o) done_cnt++;
        if (!$onehot0(weight_load_en_o)) fail_run("more than one weight lane enabled");
        for (int l = 0; l < NL; l++) begin
            if (ifmap_fifo_reset_o) begin
                ifmap_q[l].delete();
                opsum_q[l].delete();
            end
            if (weight_load_en_o[l]) begin
                check_byte($sformatf("weight lane %0d byte %0d", l, byte_cnt[l]),
                           expect_weight(l, byte_cnt[l]), weight_o);
                byte_cnt[l]++;
            end
            if (ifmap_fifo_push_o[l]) begin
                if (ifmap_fifo_full_i[l]) fail_run("push into a full ifmap FIFO");
                check_word($sformatf("ifmap lane %0d push %0d", l, push_cnt[l]),
                           expect_ifmap(l, push_cnt[l]), ifmap_fifo_push_data_o);
                push_cnt[l]++;
                ifmap_q[l].push_back(ifmap_fifo_push_data_o);
            end
            if (opsum_fifo_pop_o[l]) begin
                if (opsum_q[l].size() == 0) fail_run("pop from an empty opsum FIFO");
                void'(opsum_q[l].pop_front());
            end
            if (pe_hold[l]) begin
                if (ifmap_q[l].size() >= FIFO_DEPTH) full_cycles[l]++;
                if (full_cycles[l] >= FULL_HOLD) pe_hold[l] = 1'b0;  // lane sat full long enough
            end else if (pe_wait[l] > 0) begin
                pe_wait[l]--;
            end else if (ifmap_q[l].size() > 0 && opsum_q[l].size() < FIFO_DEPTH) begin
                opsum_q[l].push_back(ifmap_q[l].pop_front() + token_engine_pkg::glb_data_t'(l));
                pe_wait[l] = int'(rand_bits(3));
            end
        end
    end
end

// FIFO flags and head words follow the queues
always @(negedge clk) begin
    for (int l = 0; l < NL; l++) begin
        ifmap_fifo_full_i[l]     <= (ifmap_q[l].size() >= FIFO_DEPTH);
        opsum_fifo_empty_i[l]    <= (opsum_q[l].size() == 0);
        opsum_fifo_pop_data_i[l] <= (opsum_q[l].size() > 0) ? opsum_q[l][0] : '0;
    end
    ack_delay <= 3'(rand_bits(3));
end

task automatic wait_done(input int target);
    int cycles;
    cycles = 0;
    while (done_cnt < target) begin
        @(negedge clk);
        cycles++;
        if (cycles > TIMEOUT) fail_run("timeout while waiting for pass_done_o");
    end
endtask

task automatic run_pass(input token_engine_pkg::glb_addr_t wbase,
                        input token_engine_pkg::glb_addr_t ibase,
                        input token_engine_pkg::glb_addr_t obase,
                        input token_engine_pkg::tile_len_t len,
                        input token_engine_pkg::lane_mask_t hold);
    int target;
    @(negedge clk);
    weight_base_i = wbase;
    ifmap_base_i  = ibase;
    opsum_base_i  = obase;
    tile_len_i    = len;
    for (int l = 0; l < NL; l++) begin
        push_cnt[l]    = 0;
        byte_cnt[l]    = 0;
        full_cycles[l] = 0;
    end
    pe_hold      = hold;  // a held lane only drains once its FIFO was full
    target       = done_cnt + 1;
    pass_start_i = 1'b1;
    @(negedge clk);
    pass_start_i = 1'b0;
    wait_done(target);
    repeat (10) @(negedge clk);  // a stray second pulse would land here
    check_count("pass_done_o pulses", target, done_cnt);
    for (int l = 0; l < NL; l++) begin
        check_count($sformatf("weight bytes lane %0d", l), `TE_DATA_W / 8, byte_cnt[l]);
        check_count($sformatf("ifmap pushes lane %0d", l), int'(len), push_cnt[l]);
        for (int k = 0; k < int'(len); k++) begin
            check_word($sformatf("opsum lane %0d word %0d", l, k), expect_opsum(l, k),
                       u_glb_wb_model.mem[lane_word(obase, l, k)]);
        end
    end
endtask

initial begin
    for (int i = 0; i < MEM_WORDS; i++) begin
        image[i] = rand_bits(32) ^ 32'(i);
        u_glb_wb_model.mem[i] = image[i];
    end
    repeat (4) @(negedge clk);
    rst_n_i = 1'b1;
    repeat (8) begin
        @(negedge clk);
        if ({wb_cyc_o, wb_stb_o, pass_done_o, ifmap_fifo_reset_o, opsum_fifo_reset_o} !== '0
            || weight_load_en_o !== '0 || ifmap_fifo_push_o !== '0
            || opsum_fifo_pop_o !== '0) begin
            fail_run("control output active after reset with no pass started");
        end
    end
    run_pass(32'h000, 32'h100, 32'h400, 8'd6, token_engine_pkg::lane_mask_t'(6));
    run_pass(32'h040, 32'h200, 32'h600, 8'd3, '0);  // regions clear of the first writes
    $display("*** TEST PASSED ***");
    $finish;
end

endmodule
